// ==== rtl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // --------------------------------------------------------------------------
  // Widths and reset address
  // --------------------------------------------------------------------------

  localparam int xlen   = 32;
  localparam int reg_aw = 5;

  typedef logic [xlen-1:0]   word_t;
  typedef logic [reg_aw-1:0] reg_addr_t;

  // First fetch after reset
  localparam word_t reset_pc = '0;

  // EBREAK is matched on the full word, not just the opcode
  localparam word_t instr_ebreak = 32'h0010_0073;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------

  // Major opcodes kept in this core
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    res_alu,
    res_mem,
    res_pc_plus4
  } res_src_e;

endpackage

`default_nettype wire

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_pkg::word_t     instr,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::reg_addr_t rd_addr,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_e   alu_op,
  output logic              alu_b_imm,
  output logic              reg_write,
  output logic              mem_write,
  output rv_pkg::res_src_e  res_src,
  output logic              is_branch,
  output logic              branch_ne,
  output logic              is_jump,
  output logic              is_ebreak
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_j;

  // funct3 to ALU op, shared by OP and OP-IMM
  function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                       input logic sub_sel,
                                                       input logic sra_sel);
    case (f3)
      3'b000:  return sub_sel ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return sra_sel ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  assign opcode   = rv_pkg::opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm       = '0;
    alu_op    = rv_pkg::alu_add;
    alu_b_imm = 1'b0;
    reg_write = 1'b0;
    mem_write = 1'b0;
    res_src   = rv_pkg::res_alu;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_jump   = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      rv_pkg::opc_op: begin
        reg_write = 1'b1;
        alu_op    = alu_from_funct3(funct3, instr[30], instr[30]);
      end
      rv_pkg::opc_op_imm: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        imm       = imm_i;
        // No SUBI; bit 30 only selects SRAI
        alu_op    = alu_from_funct3(funct3, 1'b0, instr[30]);
      end
      rv_pkg::opc_lui: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        imm       = imm_u;
        alu_op    = rv_pkg::alu_pass_b;
      end
      rv_pkg::opc_load: begin
        // LW only
        reg_write = (funct3 == 3'b010);
        alu_b_imm = 1'b1;
        imm       = imm_i;
        res_src   = rv_pkg::res_mem;
      end
      rv_pkg::opc_store: begin
        // SW only
        mem_write = (funct3 == 3'b010);
        alu_b_imm = 1'b1;
        imm       = imm_s;
      end
      rv_pkg::opc_branch: begin
        // BEQ and BNE
        is_branch = (funct3[2:1] == 2'b00);
        branch_ne = funct3[0];
        imm       = imm_b;
      end
      rv_pkg::opc_jal: begin
        reg_write = 1'b1;
        is_jump   = 1'b1;
        res_src   = rv_pkg::res_pc_plus4;
        imm       = imm_j;
      end
      rv_pkg::opc_system: begin
        is_ebreak = (instr == rv_pkg::instr_ebreak);
      end
      default: begin
      end
    endcase
  end

  // A store never writes back, for any instruction seen
  a_no_store_writeback: assert property (@(instr) !(mem_write && reg_write));

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data
);

  // x1..x31, x0 has no storage
  rv_pkg::word_t regs [1:2**rv_pkg::reg_aw-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Combinational reads, x0 reads zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // Writes, including ones aimed at x0, leave x0 reading zero
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    we |=> (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0)
  );

endmodule

`default_nettype wire

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  input  logic            alu_b_imm,
  input  rv_pkg::alu_op_e alu_op,
  output rv_pkg::word_t   result
);

  rv_pkg::word_t a;
  rv_pkg::word_t b;
  logic [4:0]    shamt;
  logic          lt_s;
  logic          lt_u;

  // Operand B from the register file or the immediate
  assign a     = rs1_data;
  assign b     = alu_b_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  // --------------------------------------------------------------------------
  // Operation select
  // --------------------------------------------------------------------------

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_slt:    result = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
      rv_pkg::alu_sltu:   result = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = rv_pkg::word_t'($signed(a) >>> shamt);
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_and:    result = a & b;
      // LUI
      rv_pkg::alu_pass_b: result = b;
      default:            result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  input  logic          is_branch,
  input  logic          branch_ne,
  input  logic          is_jump,
  input  logic          is_ebreak,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);

  rv_pkg::word_t target;
  rv_pkg::word_t pc_next;
  logic          rs_eq;
  logic          taken;

  assign pc_plus4 = pc + 32'd4;

  // PC-relative target for JAL and branches
  assign target = pc + imm;

  // BEQ takes on equal, BNE on not equal
  assign rs_eq = (rs1_data == rs2_data);
  assign taken = is_jump || (is_branch && (rs_eq ^ branch_ne));

  always_comb begin
    if (is_ebreak) begin
      pc_next = pc;
    end else if (taken) begin
      pc_next = target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= rv_pkg::reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rst_n,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_rdata,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  input  rv_pkg::word_t dmem_rdata,
  output logic          ebreak
);

  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::reg_addr_t rd_addr;
  rv_pkg::word_t     imm;
  rv_pkg::alu_op_e   alu_op;
  logic              alu_b_imm;
  logic              reg_write;
  logic              mem_write;
  rv_pkg::res_src_e  res_src;
  logic              is_branch;
  logic              branch_ne;
  logic              is_jump;
  logic              is_ebreak;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     alu_result;
  rv_pkg::word_t     pc;
  rv_pkg::word_t     pc_plus4;
  rv_pkg::word_t     rd_data;
  logic              reg_we;

  // --------------------------------------------------------------------------
  // Units
  // --------------------------------------------------------------------------

  rv_decoder u_decoder (
    .instr    (imem_rdata),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .imm      (imm),
    .alu_op   (alu_op),
    .alu_b_imm(alu_b_imm),
    .reg_write(reg_write),
    .mem_write(mem_write),
    .res_src  (res_src),
    .is_branch(is_branch),
    .branch_ne(branch_ne),
    .is_jump  (is_jump),
    .is_ebreak(is_ebreak)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (reg_we),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  rv_alu u_alu (
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .alu_b_imm(alu_b_imm),
    .alu_op   (alu_op),
    .result   (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .is_branch(is_branch),
    .branch_ne(branch_ne),
    .is_jump  (is_jump),
    .is_ebreak(is_ebreak),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  // --------------------------------------------------------------------------
  // Memory ports and write-back
  // --------------------------------------------------------------------------

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;

  // No writes and no halt while in reset
  assign reg_we  = reg_write & rst_n;
  assign dmem_we = mem_write & rst_n;
  assign ebreak  = is_ebreak & rst_n;

  always_comb begin
    case (res_src)
      rv_pkg::res_mem:      rd_data = dmem_rdata;
      rv_pkg::res_pc_plus4: rd_data = pc_plus4;
      default:              rd_data = alu_result;
    endcase
  end

  // Halted core keeps fetching the EBREAK
  a_halt_holds: assert property (
    @(posedge clk) disable iff (!rst_n) ebreak |=> $stable(imem_addr) && !dmem_we
  );

endmodule

`default_nettype wire

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  typedef enum logic [4:0] {
    t_add, t_sub, t_sll, t_slt, t_sltu, t_xor, t_srl, t_sra, t_or, t_and,
    t_addi, t_slti, t_sltiu, t_xori, t_ori, t_andi, t_slli, t_srli, t_srai,
    t_lui, t_lw, t_beq, t_bne, t_jal
  } test_op_e;

  typedef struct packed {
    test_op_e      op;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    logic          rnd;
  } row_t;

  // JAL sits right after the four operand-building instructions
  localparam rv_pkg::word_t jal_addr = 32'd16;
  localparam int n_rows = 31;
  localparam int halt_timeout = 200;

  // Operation, operand A seed, operand B seed, LFSR flag
  row_t rows [n_rows] = '{
    '{t_add, 32'h0, 32'h0, 1'b1}, '{t_add, 32'h7fff_ffff, 32'h1, 1'b0},
    '{t_sub, 32'h0, 32'h0, 1'b1}, '{t_sub, 32'h0, 32'h1, 1'b0},
    '{t_sll, 32'h0, 32'h0, 1'b1}, '{t_slt, 32'hffff_ffff, 32'h1, 1'b0},
    '{t_slt, 32'h0, 32'h0, 1'b1}, '{t_sltu, 32'hffff_ffff, 32'h1, 1'b0},
    '{t_xor, 32'h0, 32'h0, 1'b1}, '{t_srl, 32'h0, 32'h0, 1'b1},
    '{t_sra, 32'h8000_0000, 32'h3f, 1'b0}, '{t_sra, 32'h0, 32'h0, 1'b1},
    '{t_or, 32'h0, 32'h0, 1'b1}, '{t_and, 32'h0, 32'h0, 1'b1},
    '{t_addi, 32'h5, 32'hfff, 1'b0}, '{t_addi, 32'h0, 32'h0, 1'b1},
    '{t_slti, 32'h0, 32'h0, 1'b1}, '{t_sltiu, 32'h0, 32'hfff, 1'b0},
    '{t_xori, 32'h0, 32'h0, 1'b1}, '{t_ori, 32'h0, 32'h0, 1'b1},
    '{t_andi, 32'h0, 32'h0, 1'b1}, '{t_slli, 32'h0, 32'h0, 1'b1},
    '{t_srli, 32'h0, 32'h0, 1'b1}, '{t_srai, 32'h8000_0000, 32'h4, 1'b0},
    '{t_lui, 32'h0, 32'h0, 1'b1}, '{t_lw, 32'h0, 32'h0, 1'b1},
    '{t_beq, 32'h1234_5678, 32'h1234_5678, 1'b0}, '{t_beq, 32'h0, 32'h0, 1'b1},
    '{t_bne, 32'h1234_5678, 32'h1234_5678, 1'b0}, '{t_bne, 32'h0, 32'h0, 1'b1},
    '{t_jal, 32'h0, 32'h0, 1'b0}
  };

  logic          clk;
  logic          rst_n;
  rv_pkg::word_t imem_addr;
  rv_pkg::word_t imem_rdata;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_wdata;
  logic          dmem_we;
  rv_pkg::word_t dmem_rdata;
  logic          ebreak;

  rv_pkg::word_t imem [256];
  rv_pkg::word_t dmem [256];
  rv_pkg::word_t lfsr = 32'h13d3_65df;
  int            errors = 0;
  int            timeouts = 0;
  int            prog_len;

  rv_core DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .dmem_rdata(dmem_rdata),
    .ebreak    (ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory models indexed by address bits 9:2
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic check(input rv_pkg::word_t got, input rv_pkg::word_t exp, input string msg);
    if (got !== exp) begin
      $display("** Error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  function automatic rv_pkg::word_t lfsr_next(input rv_pkg::word_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_word(output rv_pkg::word_t v);
    v = '0;
    for (int i = 0; i < 32; i++) begin
      v = {lfsr[0], v[31:1]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
                                           input rv_pkg::reg_addr_t rs1, input logic [2:0] f3,
                                           input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
  endfunction

  function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
                                           input logic [2:0] f3, input rv_pkg::reg_addr_t rd,
                                           input rv_pkg::opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t s_type(input logic [11:0] imm, input rv_pkg::reg_addr_t rs2,
                                           input rv_pkg::reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::opc_store};
  endfunction

  function automatic rv_pkg::word_t b_type(input logic [12:0] imm, input rv_pkg::reg_addr_t rs2,
                                           input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::opc_branch};
  endfunction

  function automatic rv_pkg::word_t u_type(input logic [19:0] imm, input rv_pkg::reg_addr_t rd);
    return {imm, rd, rv_pkg::opc_lui};
  endfunction

  function automatic rv_pkg::word_t j_type(input logic [20:0] imm, input rv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opc_jal};
  endfunction

  function automatic logic [2:0] funct3_of(input test_op_e op);
    case (op)
      t_sll, t_slli, t_bne:        return 3'd1;
      t_slt, t_slti:               return 3'd2;
      t_sltu, t_sltiu:             return 3'd3;
      t_xor, t_xori:               return 3'd4;
      t_srl, t_sra, t_srli, t_srai: return 3'd5;
      t_or, t_ori:                 return 3'd6;
      t_and, t_andi:               return 3'd7;
      default:                     return 3'd0;
    endcase
  endfunction

  // Reference model from the RV32I rules
  function automatic rv_pkg::word_t ref_result(input test_op_e op, input rv_pkg::word_t a,
                                               input rv_pkg::word_t b);
    rv_pkg::word_t bi;
    bi = {{20{b[11]}}, b[11:0]};
    case (op)
      t_add:   return a + b;
      t_sub:   return a - b;
      t_sll, t_slli: return a << b[4:0];
      t_slt:   return {31'b0, $signed(a) < $signed(b)};
      t_sltu:  return {31'b0, a < b};
      t_xor:   return a ^ b;
      t_srl, t_srli: return a >> b[4:0];
      t_sra, t_srai: return rv_pkg::word_t'($signed(a) >>> b[4:0]);
      t_or:    return a | b;
      t_and:   return a & b;
      t_addi:  return a + bi;
      t_slti:  return {31'b0, $signed(a) < $signed(bi)};
      t_sltiu: return {31'b0, a < bi};
      t_xori:  return a ^ bi;
      t_ori:   return a | bi;
      t_andi:  return a & bi;
      t_lui:   return {b[31:12], 12'b0};
      t_lw:    return a + b;
      t_beq:   return (a == b) ? 32'd1 : 32'd2;
      t_bne:   return (a != b) ? 32'd1 : 32'd2;
      default: return jal_addr + 32'd4;
    endcase
  endfunction

  task automatic emit(input rv_pkg::word_t instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  // Operands in x1 and x2 and the result in x3, stored to 0x100
  task automatic load_program(input test_op_e op, input rv_pkg::word_t a,
                              input rv_pkg::word_t b);
    rv_pkg::word_t ha;
    rv_pkg::word_t hb;
    logic [6:0]    f7;
    ha = a + 32'h800;
    hb = b + 32'h800;
    f7 = (op == t_sub || op == t_sra || op == t_srai) ? 7'h20 : 7'h00;
    for (int i = 0; i < 256; i++) begin
      // Harmless ADDI x0 fill that differs per word
      imem[i] = i_type(12'(i), 5'd0, 3'd0, 5'd0, rv_pkg::opc_op_imm);
      dmem[i] = 32'ha5c3_0000 ^ (i * 32'h0101_0103);
    end
    prog_len = 0;
    emit(u_type(ha[31:12], 5'd1));
    emit(i_type(a[11:0], 5'd1, 3'd0, 5'd1, rv_pkg::opc_op_imm));
    emit(u_type(hb[31:12], 5'd2));
    emit(i_type(b[11:0], 5'd2, 3'd0, 5'd2, rv_pkg::opc_op_imm));
    case (op)
      t_add, t_sub, t_sll, t_slt, t_sltu, t_xor, t_srl, t_sra, t_or, t_and:
        emit(r_type(f7, 5'd2, 5'd1, funct3_of(op), 5'd3));
      t_slli, t_srli, t_srai:
        emit(i_type({f7, b[4:0]}, 5'd1, funct3_of(op), 5'd3, rv_pkg::opc_op_imm));
      t_lui:
        emit(u_type(b[31:12], 5'd3));
      t_lw: begin
        dmem[32] = a;
        emit(i_type(12'h080, 5'd0, 3'b010, 5'd3, rv_pkg::opc_load));
        emit(r_type(7'h00, 5'd2, 5'd3, 3'd0, 5'd3));
      end
      t_beq, t_bne: begin
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd3, rv_pkg::opc_op_imm));
        emit(b_type(13'd8, 5'd2, 5'd1, funct3_of(op)));
        emit(i_type(12'd2, 5'd0, 3'd0, 5'd3, rv_pkg::opc_op_imm));
      end
      t_jal: begin
        emit(j_type(21'd8, 5'd3));
        emit(i_type(12'd7, 5'd0, 3'd0, 5'd3, rv_pkg::opc_op_imm));
      end
      default:
        emit(i_type(b[11:0], 5'd1, funct3_of(op), 5'd3, rv_pkg::opc_op_imm));
    endcase
    emit(s_type(12'h100, 5'd3, 5'd0));
    emit(rv_pkg::instr_ebreak);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t ra;
    rv_pkg::word_t rb;
    rv_pkg::word_t hold_pc;
    rv_pkg::word_t first_instr;
    logic          halted;
    rst_n = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      a = rows[r].a;
      b = rows[r].b;
      if (rows[r].rnd) begin
        random_word(ra);
        random_word(rb);
        a = a ^ ra;
        b = b ^ rb;
      end
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      load_program(rows[r].op, a, b);
      first_instr = imem[0];
      for (int i = 0; i < 10; i++) begin
        // EBREAK and then SW at the reset address stay inert in reset
        if (i < 3) begin
          imem[0] = rv_pkg::instr_ebreak;
        end else if (i < 6) begin
          imem[0] = s_type(12'h100, 5'd3, 5'd0);
        end else begin
          imem[0] = first_instr;
        end
        @(negedge clk);
        check(imem_addr, rv_pkg::reset_pc, "imem_addr during reset");
        check(dmem_we, '0, "dmem_we during reset");
        check(ebreak, '0, "ebreak during reset");
        @(posedge clk);
        #1;
      end
      rst_n = 1'b1;
      halted = 1'b0;
      for (int cyc = 0; cyc < halt_timeout && !halted; cyc++) begin
        @(negedge clk);
        halted = ebreak;
      end
      if (!halted) begin
        $display("Timeout: row %0d did not reach EBREAK within %0d cycles", r, halt_timeout);
        timeouts++;
      end else begin
        // EBREAK is the last word of the program
        hold_pc = rv_pkg::word_t'((prog_len - 1) * 4);
        check(imem_addr, hold_pc, $sformatf("row %0d pc at ebreak", r));
        // Halted core must not move or write
        repeat (5) begin
          @(negedge clk);
          check(imem_addr, hold_pc, $sformatf("row %0d pc held after ebreak", r));
          check(dmem_we, '0, $sformatf("row %0d dmem_we after ebreak", r));
        end
        check(dmem[64], ref_result(rows[r].op, a, b),
              $sformatf("row %0d op %s a %h b %h", r, rows[r].op.name(), a, b));
      end
    end
    $display("Finished %0d rows: %0d errors, %0d timeouts", n_rows, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_core.sv
test/tb_rv_core.sv
